//--- flist.f
+incdir+.
logic/ccu_snoop_pkg.sv
logic/ccu_order_pkg.sv
logic/cd_order_if.sv
logic/ccu_fifo.sv
logic/cd_order_ctrl.sv
logic/cd_port_sel.sv
logic/ccu_cd_top.sv
dv/tb_ccu_cd_top.sv

//--- Bender.yml
package:
  name: ccu_cd

export_include_dirs:
  - .

sources:
  - logic/ccu_snoop_pkg.sv
  - logic/ccu_order_pkg.sv
  - logic/cd_order_if.sv
  - logic/ccu_fifo.sv
  - logic/cd_order_ctrl.sv
  - logic/cd_port_sel.sv
  - logic/ccu_cd_top.sv
  - target: test
    files:
      - dv/tb_ccu_cd_top.sv

//--- dv/tb_ccu_cd_top.sv
/* Testbench for the snoop-data path: clock, reset, port models,
 * scoreboard assertions, per-test report and timeout
 */

`timescale 1ns/1ps
`default_nettype none

`include "ccu_cd_defs.svh"

module tb_ccu_cd_top;

    localparam int unsigned NP = `CCU_NUM_PORTS;
    // Six tests of under a hundred cycles each, plus reset, with wide margin
    localparam int unsigned MAX_CYCLES = 2000;

    logic                      clk_i, rst_ni;
    logic                      mu_wb_req_i, mu_gnt_i, su_rd_req_i, su_gnt_i;
    ccu_snoop_pkg::port_idx_t  first_responder_i;
    ccu_snoop_pkg::port_mask_t data_avail_i;
    logic                      order_stall_o;
    logic [NP-1:0]             cd_valid_i, cd_ready_o;
    ccu_snoop_pkg::cd_beat_t   cd_beat_i [NP];
    logic                      mu_valid_o, mu_ready_i, su_valid_o, su_ready_i;
    ccu_snoop_pkg::cd_beat_t   mu_beat_o, su_beat_o;

    integer      seed = 1787;
    int unsigned errors = 0;
    int unsigned cycles = 0;
    int unsigned tests_run = 0;
    int unsigned last_out = 0;
    logic        others_done;

    // Model of the ordering queue and of the beats due at each sink
    ccu_order_pkg::order_entry_t order_q [$];
    ccu_order_pkg::order_entry_t head_m;
    ccu_snoop_pkg::port_mask_t   last_m = '0;
    ccu_snoop_pkg::cd_beat_t     exp_mu [$];
    ccu_snoop_pkg::cd_beat_t     exp_su [$];
    ccu_snoop_pkg::cd_beat_t     got;

    ccu_cd_top u_dut (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .mu_wb_req_i       (mu_wb_req_i),
        .mu_gnt_i          (mu_gnt_i),
        .su_rd_req_i       (su_rd_req_i),
        .su_gnt_i          (su_gnt_i),
        .first_responder_i (first_responder_i),
        .data_avail_i      (data_avail_i),
        .order_stall_o     (order_stall_o),
        .cd_valid_i        (cd_valid_i),
        .cd_beat_i         (cd_beat_i),
        .cd_ready_o        (cd_ready_o),
        .mu_valid_o        (mu_valid_o),
        .mu_beat_o         (mu_beat_o),
        .mu_ready_i        (mu_ready_i),
        .su_valid_o        (su_valid_o),
        .su_beat_o         (su_beat_o),
        .su_ready_i        (su_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    mu_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mu_valid_o && !mu_ready_i |=> mu_valid_o && $stable(mu_beat_o))
    else begin
        errors++;
        $display("Error at %0t: mu sink beat dropped or changed before mu_ready_i", $time);
    end

    su_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        su_valid_o && !su_ready_i |=> su_valid_o && $stable(su_beat_o))
    else begin
        errors++;
        $display("Error at %0t: su sink beat dropped or changed before su_ready_i", $time);
    end

    always @(posedge clk_i) begin
        if (rst_ni) begin
            for (int p = 0; p < NP; p++) begin
                assert (!cd_ready_o[p] ||
                        (order_q.size() > 0 && order_q[0].avail[p] && !last_m[p]))
                else begin
                    errors++;
                    $display("FAILED t=%0t cd_ready_o[%0d] expected 0 got 1", $time, p);
                end
            end
            // Head retires one cycle after its final last beat
            if (order_q.size() > 0) begin
                head_m = order_q[0];
                if (last_m == head_m.avail) begin
                    void'(order_q.pop_front());
                    last_m = '0;
                end else begin
                    for (int p = 0; p < NP; p++) begin
                        if (cd_valid_i[p] && cd_ready_o[p]) begin
                            if (p == head_m.first && head_m.user == ccu_order_pkg::SNOOP_UNIT) begin
                                exp_su.push_back(cd_beat_i[p]);
                            end else if (p == head_m.first) begin
                                exp_mu.push_back(cd_beat_i[p]);
                            end
                            if (cd_beat_i[p].last) begin
                                last_m[p] = 1'b1;
                            end
                        end
                    end
                end
            end
            assert (!mu_valid_o || exp_mu.size() > 0)
            else begin
                errors++;
                $display("FAILED t=%0t mu_valid_o expected 0 got 1", $time);
            end
            if (mu_valid_o && mu_ready_i && exp_mu.size() > 0) begin
                got = exp_mu.pop_front();
                assert (mu_beat_o == got)
                else begin
                    errors++;
                    $display("FAILED t=%0t mu_beat_o expected %h got %h", $time, got, mu_beat_o);
                end
                last_out += mu_beat_o.last;
            end
            assert (!su_valid_o || exp_su.size() > 0)
            else begin
                errors++;
                $display("FAILED t=%0t su_valid_o expected 0 got 1", $time);
            end
            if (su_valid_o && su_ready_i && exp_su.size() > 0) begin
                got = exp_su.pop_front();
                assert (su_beat_o == got)
                else begin
                    errors++;
                    $display("FAILED t=%0t su_beat_o expected %h got %h", $time, got, su_beat_o);
                end
                last_out += su_beat_o.last;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    task automatic expect_val(input string name, input logic [63:0] val, input logic [63:0] exp);
        assert (val === exp)
        else begin
            errors++;
            $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, val);
        end
    endtask

    task automatic issue_request(input logic su, input ccu_snoop_pkg::port_idx_t first,
                                 input ccu_snoop_pkg::port_mask_t avail);
        ccu_order_pkg::order_entry_t e;
        e.user = ccu_order_pkg::MEMORY_UNIT;
        if (su) begin
            e.user = ccu_order_pkg::SNOOP_UNIT;
        end
        e.first = first;
        e.avail = avail;
        @(negedge clk_i);
        first_responder_i = first;
        data_avail_i      = avail;
        mu_wb_req_i       = !su;
        su_rd_req_i       = su;
        // Waits here while the ordering queue is full
        while (order_stall_o) @(negedge clk_i);
        order_q.push_back(e);
        @(negedge clk_i);
        mu_gnt_i = !su;
        su_gnt_i = su;
        @(negedge clk_i);
        {mu_wb_req_i, mu_gnt_i, su_rd_req_i, su_gnt_i} = '0;
    endtask

    task automatic send_port(input int p, input int n);
        for (int k = 0; k < n; k++) begin
            @(negedge clk_i);
            cd_valid_i[p]     = 1'b1;
            cd_beat_i[p].data = {$random(seed), $random(seed)};
            cd_beat_i[p].last = (k == n - 1);
            @(posedge clk_i);
            while (!cd_ready_o[p]) @(posedge clk_i);
        end
        @(negedge clk_i);
        cd_valid_i[p] = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk_i);
        while (order_q.size() > 0 || exp_mu.size() > 0 || exp_su.size() > 0) @(negedge clk_i);
    endtask

    task automatic report_test(input int num, input string name, input int unsigned mark,
                               input int unsigned lasts, input int unsigned want);
        expect_val("sink last beats", last_out - lasts, want);
        tests_run++;
        $display("Test %0d %s: %s", num, name, (errors == mark) ? "passed" : "has errors");
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int unsigned mark;
        int unsigned lasts;
        {mu_wb_req_i, mu_gnt_i, su_rd_req_i, su_gnt_i} = '0;
        first_responder_i = '0;
        data_avail_i      = '0;
        cd_valid_i        = '0;
        for (int p = 0; p < NP; p++) begin
            cd_beat_i[p] = '0;
        end
        mu_ready_i  = 1'b1;
        su_ready_i  = 1'b1;
        others_done = 1'b0;
        rst_ni      = 1'b0;
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;

        mark = errors;
        lasts = last_out;
        @(posedge clk_i);
        expect_val("cd_ready_o", cd_ready_o, '0);
        expect_val("mu_valid_o", mu_valid_o, 1'b0);
        expect_val("su_valid_o", su_valid_o, 1'b0);
        expect_val("order_stall_o", order_stall_o, 1'b0);
        report_test(1, "reset state", mark, lasts, 0);

        mark = errors;
        lasts = last_out;
        issue_request(1'b0, 2, 4'b0110);
        fork
            send_port(2, 4);
            send_port(1, 2);
        join
        wait_idle();
        report_test(2, "write-back routing", mark, lasts, 1);

        // Snoop sink held back for a few cycles
        mark = errors;
        lasts = last_out;
        @(negedge clk_i);
        su_ready_i = 1'b0;
        issue_request(1'b1, 0, 4'b1001);
        fork
            send_port(0, 3);
            send_port(3, 1);
            begin
                repeat (6) @(posedge clk_i);
                @(negedge clk_i);
                su_ready_i = 1'b1;
            end
        join
        wait_idle();
        report_test(3, "snoop read routing", mark, lasts, 1);

        // Port 2 offers its beats early and must wait for the first entry
        mark = errors;
        lasts = last_out;
        issue_request(1'b0, 0, 4'b0011);
        issue_request(1'b1, 2, 4'b0100);
        fork
            send_port(0, 3);
            send_port(1, 2);
            send_port(2, 2);
        join
        wait_idle();
        report_test(4, "in-order service", mark, lasts, 2);

        mark = errors;
        lasts = last_out;
        @(negedge clk_i);
        mu_ready_i = 1'b0;
        issue_request(1'b0, 1, 4'b1011);
        fork
            send_port(1, 4);
            begin
                send_port(0, 2);
                send_port(3, 2);
                others_done = 1'b1;
            end
            begin
                repeat (14) @(posedge clk_i);
                expect_val("cd_ready_o[1]", cd_ready_o[1], 1'b0);
                expect_val("non-first ports drained", others_done, 1'b1);
                @(negedge clk_i);
                mu_ready_i = 1'b1;
            end
        join
        wait_idle();
        report_test(5, "sink back-pressure", mark, lasts, 1);

        mark = errors;
        lasts = last_out;
        issue_request(1'b0, 0, 4'b0001);
        issue_request(1'b1, 1, 4'b0010);
        issue_request(1'b0, 2, 4'b0100);
        issue_request(1'b1, 3, 4'b1000);
        @(posedge clk_i);
        expect_val("order_stall_o", order_stall_o, 1'b1);
        fork
            issue_request(1'b0, 0, 4'b0001);
            begin
                repeat (4) @(posedge clk_i);
                expect_val("order_stall_o", order_stall_o, 1'b1);
                send_port(0, 1);
            end
        join
        @(posedge clk_i);
        expect_val("order_stall_o", order_stall_o, 1'b1);
        fork
            send_port(1, 1);
            send_port(2, 2);
            send_port(3, 1);
            send_port(0, 1);
        join
        wait_idle();
        report_test(6, "ordering queue stall", mark, lasts, 5);

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/ccu_cd_top.sv
/* Snoop-data path top: ordering controller, port selector
 * and the memory-unit and snoop-unit sink buffers
 */

`timescale 1ns/1ps
`default_nettype none

`include "ccu_cd_defs.svh"

module ccu_cd_top (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,

    // Requests from the memory and snoop units
    input  wire logic                      mu_wb_req_i,
    input  wire logic                      mu_gnt_i,
    input  wire logic                      su_rd_req_i,
    input  wire logic                      su_gnt_i,
    input  wire ccu_snoop_pkg::port_idx_t  first_responder_i,
    input  wire ccu_snoop_pkg::port_mask_t data_avail_i,
    output logic                           order_stall_o,

    // CD channels of the snoop ports
    input  wire logic [`CCU_NUM_PORTS-1:0] cd_valid_i,
    input  wire ccu_snoop_pkg::cd_beat_t   cd_beat_i [`CCU_NUM_PORTS],
    output logic [`CCU_NUM_PORTS-1:0]      cd_ready_o,

    // Sink outputs
    output logic                           mu_valid_o,
    output ccu_snoop_pkg::cd_beat_t        mu_beat_o,
    input  wire logic                      mu_ready_i,
    output logic                           su_valid_o,
    output ccu_snoop_pkg::cd_beat_t        su_beat_o,
    input  wire logic                      su_ready_i
);

    cd_order_if order ();

    ccu_snoop_pkg::cd_beat_t beat;
    logic                    mu_push, su_push;
    logic                    mu_full, su_full;
    logic                    mu_empty, su_empty;

    cd_order_ctrl u_order_ctrl (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .mu_wb_req_i       (mu_wb_req_i),
        .mu_gnt_i          (mu_gnt_i),
        .su_rd_req_i       (su_rd_req_i),
        .su_gnt_i          (su_gnt_i),
        .first_responder_i (first_responder_i),
        .data_avail_i      (data_avail_i),
        .stall_o           (order_stall_o),
        .order             (order.ctrl)
    );

    cd_port_sel u_port_sel (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .order      (order.sel),
        .cd_valid_i (cd_valid_i),
        .cd_beat_i  (cd_beat_i),
        .cd_ready_o (cd_ready_o),
        .mu_push_o  (mu_push),
        .su_push_o  (su_push),
        .beat_o     (beat),
        .mu_full_i  (mu_full),
        .su_full_i  (su_full)
    );

    //////////////////////////////////////////////////
    // Sink buffers
    //////////////////////////////////////////////////

    ccu_fifo #(
        .DEPTH  (`CCU_SINK_DEPTH),
        .data_t (ccu_snoop_pkg::cd_beat_t)
    ) u_mu_sink (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (mu_push),
        .data_i  (beat),
        .pop_i   (mu_ready_i),
        .data_o  (mu_beat_o),
        .full_o  (mu_full),
        .empty_o (mu_empty)
    );

    ccu_fifo #(
        .DEPTH  (`CCU_SINK_DEPTH),
        .data_t (ccu_snoop_pkg::cd_beat_t)
    ) u_su_sink (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (su_push),
        .data_i  (beat),
        .pop_i   (su_ready_i),
        .data_o  (su_beat_o),
        .full_o  (su_full),
        .empty_o (su_empty)
    );

    assign mu_valid_o = !mu_empty;
    assign su_valid_o = !su_empty;

endmodule

`default_nettype wire

//--- logic/cd_port_sel.sv
/* Per-port CD ready, last tracking and retirement,
 * steering of first-responder beats into the sinks
 */

`timescale 1ns/1ps
`default_nettype none

`include "ccu_cd_defs.svh"

module cd_port_sel (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    cd_order_if.sel                       order,
    input  wire logic [`CCU_NUM_PORTS-1:0] cd_valid_i,
    input  wire ccu_snoop_pkg::cd_beat_t  cd_beat_i [`CCU_NUM_PORTS],
    output logic [`CCU_NUM_PORTS-1:0]     cd_ready_o,
    output logic                          mu_push_o,
    output logic                          su_push_o,
    output ccu_snoop_pkg::cd_beat_t       beat_o,
    input  wire logic                     mu_full_i,
    input  wire logic                     su_full_i
);

    ccu_snoop_pkg::port_mask_t last_q;
    ccu_snoop_pkg::port_mask_t last_hs;
    logic                      sel_full;
    logic                      fr_hs;

    //////////////////////////////////////////////////
    // Ready per port
    //////////////////////////////////////////////////

    assign sel_full = (order.head_user == ccu_order_pkg::MEMORY_UNIT) ? mu_full_i : su_full_i;

    always_comb begin
        for (int i = 0; i < `CCU_NUM_PORTS; i++) begin
            cd_ready_o[i] = order.head_valid && order.head_avail[i] && !last_q[i];
            // Sink full holds back only the first responder
            if (ccu_snoop_pkg::port_idx_t'(i) == order.head_first && sel_full) begin
                cd_ready_o[i] = 1'b0;
            end
            last_hs[i] = cd_valid_i[i] && cd_ready_o[i] && cd_beat_i[i].last;
        end
    end

    //////////////////////////////////////////////////
    // Last tracking and retirement
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= '0;
        end else if (order.pop) begin
            last_q <= '0;
        end else begin
            last_q <= last_q | last_hs;
        end
    end

    // Every port with data has sent its last beat
    assign order.pop = order.head_valid && (last_q == order.head_avail);

    //////////////////////////////////////////////////
    // Steering
    //////////////////////////////////////////////////

    assign fr_hs  = cd_valid_i[order.head_first] && cd_ready_o[order.head_first];
    assign beat_o = cd_beat_i[order.head_first];

    // Beats of other ports are taken and dropped
    assign mu_push_o = fr_hs && (order.head_user == ccu_order_pkg::MEMORY_UNIT);
    assign su_push_o = fr_hs && (order.head_user == ccu_order_pkg::SNOOP_UNIT);

endmodule

`default_nettype wire

//--- logic/cd_order_ctrl.sv
/* Request capture with memory priority, push-once flag
 * and the CD ordering queue
 */

`timescale 1ns/1ps
`default_nettype none

`include "ccu_cd_defs.svh"

module cd_order_ctrl (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      mu_wb_req_i,
    input  wire logic                      mu_gnt_i,
    input  wire logic                      su_rd_req_i,
    input  wire logic                      su_gnt_i,
    input  wire ccu_snoop_pkg::port_idx_t  first_responder_i,
    input  wire ccu_snoop_pkg::port_mask_t data_avail_i,
    output logic                           stall_o,
    cd_order_if.ctrl                       order
);

    ccu_order_pkg::order_entry_t entry_in, head;
    logic                        push, empty;
    logic                        pushed_d, pushed_q;
    logic                        gnt;

    //////////////////////////////////////////////////
    // Request capture
    //////////////////////////////////////////////////

    always_comb begin
        entry_in.user  = ccu_order_pkg::MEMORY_UNIT;
        entry_in.first = first_responder_i;
        entry_in.avail = data_avail_i;
        push           = 1'b0;
        gnt            = 1'b0;
        if (mu_wb_req_i) begin
            push = !pushed_q && !stall_o;
            gnt  = mu_gnt_i;
        end else if (su_rd_req_i) begin
            entry_in.user = ccu_order_pkg::SNOOP_UNIT;
            push          = !pushed_q && !stall_o;
            gnt           = su_gnt_i;
        end
        // Held until the grant ends the request
        pushed_d = gnt ? 1'b0 : (pushed_q || push);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pushed_q <= 1'b0;
        end else begin
            pushed_q <= pushed_d;
        end
    end

    //////////////////////////////////////////////////
    // Ordering queue
    //////////////////////////////////////////////////

    ccu_fifo #(
        .DEPTH  (`CCU_ORDER_DEPTH),
        .data_t (ccu_order_pkg::order_entry_t)
    ) u_order_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (push),
        .data_i  (entry_in),
        .pop_i   (order.pop),
        .data_o  (head),
        .full_o  (stall_o),
        .empty_o (empty)
    );

    assign order.head_valid = !empty;
    assign order.head_user  = head.user;
    assign order.head_first = head.first;
    assign order.head_avail = head.avail;

endmodule

`default_nettype wire

//--- logic/ccu_fifo.sv
/* Fall-through FIFO with a type-parameter payload
 */

`timescale 1ns/1ps
`default_nettype none

module ccu_fifo #(
    parameter int unsigned DEPTH = 2,
    parameter type data_t = logic
) (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  push_i,
    input  wire data_t data_i,
    input  wire logic  pop_i,
    output data_t      data_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    data_t            mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             none_stored, fall_thru, do_push, do_pop;

    assign none_stored = (count_q == '0);
    assign full_o      = (count_q == CNT_W'(DEPTH));
    assign empty_o     = none_stored && !push_i;

    // Beat passes straight through without being stored
    assign fall_thru = none_stored && push_i && pop_i;
    assign do_push   = push_i && !full_o && !fall_thru;
    assign do_pop    = pop_i && !none_stored;

    assign data_o = none_stored ? data_i : mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/cd_order_if.sv
/* Head of the CD ordering queue and its pop strobe
 */

`timescale 1ns/1ps
`default_nettype none

interface cd_order_if;

    logic                      head_valid;
    ccu_order_pkg::cd_user_e   head_user;
    ccu_snoop_pkg::port_idx_t  head_first;
    ccu_snoop_pkg::port_mask_t head_avail;
    logic                      pop;

    // Queue side
    modport ctrl (output head_valid, head_user, head_first, head_avail, input pop);

    // Routing side that pops once all data ports are done
    modport sel (input head_valid, head_user, head_first, head_avail, output pop);

endinterface

`default_nettype wire

//--- logic/ccu_order_pkg.sv
/* Ordering types: owner of a CD transfer and one ordering record
 */

`default_nettype none

package ccu_order_pkg;

    // Owner of the CD data of one request
    typedef enum logic {
        MEMORY_UNIT = 1'b0,
        SNOOP_UNIT  = 1'b1
    } cd_user_e;

    // One ordering record
    typedef struct packed {
        cd_user_e                 user;
        ccu_snoop_pkg::port_idx_t first;
        ccu_snoop_pkg::port_mask_t avail;
    } order_entry_t;

endpackage

`default_nettype wire

//--- logic/ccu_snoop_pkg.sv
/* Snoop-channel types: port index, port mask and the CD beat
 */

`default_nettype none

`include "ccu_cd_defs.svh"

package ccu_snoop_pkg;

    // Index of one snoop port
    typedef logic [$clog2(`CCU_NUM_PORTS)-1:0] port_idx_t;

    // One bit per snoop port
    typedef logic [`CCU_NUM_PORTS-1:0] port_mask_t;

    // One CD beat
    typedef struct packed {
        logic [`CCU_CD_DATA_W-1:0] data;
        logic                      last;
    } cd_beat_t;

endpackage

`default_nettype wire

//--- ccu_cd_defs.svh
/* Size and depth constants of the snoop-data path
 */

`ifndef CCU_CD_DEFS_SVH
`define CCU_CD_DEFS_SVH

// Snoop ports sharing the CD channels
`define CCU_NUM_PORTS 4

// Data bits in one CD beat
`define CCU_CD_DATA_W 64

// Entries in the ordering queue and in each sink buffer
`define CCU_ORDER_DEPTH 4
`define CCU_SINK_DEPTH 2

`endif
